// ==== Makefile ====
# Verilator flow for the SD host controller.
# Override on the command line, for example: make sim SEED=42 LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_sd_host
FILELIST  ?= verilog.f
SEED      ?= 1109
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_sd_host.sv ====
`timescale 1ns/1ps

module tb_sd_host import sd_reg_pkg::*, sd_bus_pkg::*; #(
  parameter int SEED = 32'h455
);

  localparam int DIV_SLOW    = 6;
  localparam int N_BYTES     = 4;
  // Slowest access is a 1-bit byte at DIV_SLOW, about 16 * DIV_SLOW cycles.
  localparam int ACK_LIMIT   = 40 * DIV_SLOW;
  localparam int CYCLE_LIMIT = 20000;

  logic                wb_clk_i;
  logic                wb_rst_i;
  logic                wb_cyc_i;
  logic                wb_stb_i;
  logic                wb_we_i;
  logic [2:0]          wb_adr_i;
  logic [7:0]          wb_dat_i;
  logic [7:0]          wb_dat_o;
  logic                wb_ack_o;
  logic                sd_clk_o;
  logic                sd_cmd_o;
  logic                sd_cmd_oe_o;
  logic                sd_cmd_i;
  logic [SD_LANES-1:0] sd_dat_o;
  logic                sd_dat_oe_o;
  logic [SD_LANES-1:0] sd_dat_i;

  integer              seed;
  int                  errors = 0;
  int                  cycle_cnt = 0;
  logic                cmd_in_q[$];
  logic [3:0]          dat_in_q[$];
  logic                cmd_rec[$];
  logic [3:0]          dat_rec[$];
  logic [SD_CRC_W-1:0] ref_crc [SD_LANES];

  sd_host_top #(
    .DIV_SLOW (DIV_SLOW)
  ) i_dut (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .sd_clk_o    (sd_clk_o),
    .sd_cmd_o    (sd_cmd_o),
    .sd_cmd_oe_o (sd_cmd_oe_o),
    .sd_cmd_i    (sd_cmd_i),
    .sd_dat_o    (sd_dat_o),
    .sd_dat_oe_o (sd_dat_oe_o),
    .sd_dat_i    (sd_dat_i)
  );

  initial wb_clk_i = 1'b0;
  always #20 wb_clk_i = ~wb_clk_i;

  task automatic stop_on_error();
    errors = errors + 1;
    $display("*** TEST FAILED ***");
    $fatal(1, "Stopped at the first error");
  endtask

  always @(posedge wb_clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
      stop_on_error();
    end
  end

  // Card model presents the next value after the SD clock falls.
  always @(negedge sd_clk_o) begin
    @(negedge wb_clk_i);
    if (cmd_in_q.size() > 0) begin
      sd_cmd_i = cmd_in_q.pop_front();
    end
    if (dat_in_q.size() > 0) begin
      sd_dat_i = dat_in_q.pop_front();
    end
  end

  // Outputs are recorded on the rising SD clock.
  always @(posedge sd_clk_o) begin
    @(negedge wb_clk_i);
    cmd_rec.push_back(sd_cmd_o);
    dat_rec.push_back(sd_dat_o);
  end

  task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected 0x%02h, actual 0x%02h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic compare_clk(input string name, input sd_clk_reg_t exp, input sd_clk_reg_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected 0x%02h, actual 0x%02h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic compare_crc(input string name, input logic [SD_CRC_W-1:0] exp,
                             input logic [SD_CRC_W-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected 0x%04h, actual 0x%04h", name, exp, act);
      stop_on_error();
    end
  endtask

  // CRC16-CCITT step, x^16 + x^12 + x^5 + 1.
  function automatic logic [SD_CRC_W-1:0] crc16_next(input logic [SD_CRC_W-1:0] crc,
                                                     input logic b);
    logic                fb;
    logic [SD_CRC_W-1:0] c;
    fb    = crc[15] ^ b;
    c     = {crc[14:0], fb};
    c[12] = c[12] ^ fb;
    c[5]  = c[5] ^ fb;
    return c;
  endfunction

  function automatic sd_clk_reg_t clk_cfg(input sd_dat_width_e w, input sd_clk_width_e s);
    sd_clk_reg_t c;
    c            = '0;
    c.dat_oe     = 1'b1;
    c.cmd_oe     = 1'b1;
    c.data_width = w;
    c.clk_width  = s;
    return c;
  endfunction

  function automatic logic [7:0] auto_byte(input sd_adv_mode_e mode, input logic avail);
    return {2'b00, mode, 3'b000, avail};
  endfunction

  task automatic draw_byte(output logic [7:0] b);
    logic [31:0] r;
    r = $random(seed);
    b = r[7:0];
  endtask

  // One Wishbone access, started on a falling edge and ended at ack.
  task automatic wb_access(input logic we, input sd_reg_addr_e adr, input logic [7:0] din,
                           output logic [7:0] dout);
    int wait_cnt;
    wait_cnt = 0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = din;
    @(negedge wb_clk_i);
    while ((wb_ack_o !== 1'b1) && (wait_cnt <= ACK_LIMIT)) begin
      wait_cnt = wait_cnt + 1;
      @(negedge wb_clk_i);
    end
    dout     = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (wait_cnt > ACK_LIMIT) begin
      $display("Timeout: no Wishbone ack within %0d cycles at address %0d", ACK_LIMIT, adr);
      stop_on_error();
    end
  endtask

  task automatic wb_write(input sd_reg_addr_e adr, input logic [7:0] din);
    logic [7:0] unused;
    wb_access(1'b1, adr, din, unused);
  endtask

  task automatic wb_read(input sd_reg_addr_e adr, output logic [7:0] dout);
    wb_access(1'b0, adr, 8'h00, dout);
  endtask

  task automatic wait_man_done();
    logic [7:0] rd;
    int         polls;
    rd    = 8'h00;
    polls = 0;
    while ((rd[0] !== 1'b1) && (polls < ACK_LIMIT)) begin
      wb_read(REG_ADV, rd);
      polls = polls + 1;
    end
    if (rd[0] !== 1'b1) begin
      $display("Timeout: ADV never reported the manual advance as done");
      stop_on_error();
    end
  endtask

  task automatic check_reset_state();
    logic [7:0] rd;
    wb_read(REG_CLK, rd);
    compare_byte("reset CLK", 8'h03, rd);
    wb_read(REG_AUTO, rd);
    compare_byte("reset AUTO", 8'h00, rd);
    wb_read(REG_ADV, rd);
    compare_byte("reset ADV", 8'h00, rd);
    compare_byte("reset output enables", 8'h00, {6'b0, sd_dat_oe_o, sd_cmd_oe_o});
    compare_byte("reset sd_clk", 8'h00, {7'b0, sd_clk_o});
  endtask

  task automatic check_readback();
    sd_clk_reg_t exp_clk;
    sd_clk_reg_t act_clk;
    logic [7:0]  rd;
    exp_clk = clk_cfg(DW_4, W_40M);
    wb_write(REG_CLK, exp_clk);
    wb_read(REG_CLK, rd);
    act_clk = rd;
    compare_clk("CLK readback", exp_clk, act_clk);
    compare_byte("output enables", 8'h03, {6'b0, sd_dat_oe_o, sd_cmd_oe_o});
    wb_write(REG_AUTO, auto_byte(ADV_DAT_WR, 1'b0));
    wb_read(REG_AUTO, rd);
    compare_byte("AUTO mode readback", auto_byte(ADV_DAT_WR, 1'b0), rd);
    wb_write(REG_AUTO, auto_byte(ADV_NONE, 1'b0));
  endtask

  task automatic check_cmd_advance();
    logic [7:0] tx;
    logic [7:0] rx;
    logic [7:0] rd;
    wb_write(REG_CLK, clk_cfg(DW_4, W_20M));
    draw_byte(tx);
    draw_byte(rx);
    // First bit goes on the line now. The rest follow each falling edge.
    sd_cmd_i = rx[7];
    for (int i = 6; i >= 0; i--) begin
      cmd_in_q.push_back(rx[i]);
    end
    for (int i = 7; i >= 0; i--) begin
      cmd_rec.delete();
      wb_write(REG_CMD, {7'b0, tx[i]});
      wb_write(REG_ADV, 8'h01);
      wait_man_done();
      compare_byte("SD clocks per command bit", 8'd1, 8'(cmd_rec.size()));
      compare_byte("sd_cmd_o bit", {7'b0, tx[i]}, {7'b0, cmd_rec[0]});
    end
    wb_read(REG_CMD, rd);
    compare_byte("CMD received bits", rx, rd);
  endtask

  task automatic check_byte_write();
    logic [7:0] b;
    logic [7:0] rebuilt;
    wb_write(REG_CLK, clk_cfg(DW_1, W_365K));
    wb_write(REG_AUTO, auto_byte(ADV_DAT_WR, 1'b0));
    for (int n = 0; n < N_BYTES; n++) begin
      draw_byte(b);
      dat_rec.delete();
      wb_write(REG_DAT, b);
      compare_byte("SD clocks before ack", 8'd8, 8'(dat_rec.size()));
      rebuilt = 8'h00;
      foreach (dat_rec[k]) begin
        rebuilt = {rebuilt[6:0], dat_rec[k][0]};
      end
      compare_byte("byte on DAT0", b, rebuilt);
      for (int k = 7; k >= 0; k--) begin
        ref_crc[0] = crc16_next(ref_crc[0], b[k]);
      end
    end
  endtask

  task automatic check_byte_read();
    logic [7:0] tx [N_BYTES];
    logic [7:0] rd;
    wb_write(REG_CLK, clk_cfg(DW_4, W_40M));
    wb_write(REG_AUTO, auto_byte(ADV_DAT_RD, 1'b0));
    for (int n = 0; n < N_BYTES; n++) begin
      draw_byte(tx[n]);
    end
    sd_dat_i = tx[0][7:4];
    dat_in_q.push_back(tx[0][3:0]);
    for (int n = 1; n < N_BYTES; n++) begin
      dat_in_q.push_back(tx[n][7:4]);
      dat_in_q.push_back(tx[n][3:0]);
    end
    for (int n = 0; n < N_BYTES; n++) begin
      wb_read(REG_DAT, rd);
      compare_byte("DAT read byte", tx[n], rd);
      for (int l = 0; l < SD_LANES; l++) begin
        ref_crc[l] = crc16_next(crc16_next(ref_crc[l], tx[n][4+l]), tx[n][l]);
      end
      wb_read(REG_AUTO, rd);
      compare_byte("AUTO after read", auto_byte(ADV_DAT_RD, 1'b1), rd);
    end
    wb_write(REG_AUTO, auto_byte(ADV_NONE, 1'b0));
  endtask

  task automatic check_crc_lanes(input logic cleared);
    logic [7:0] hi;
    logic [7:0] lo;
    for (int l = 0; l < SD_LANES; l++) begin
      wb_write(REG_CRC_CMD, {2'b00, 2'(l), 4'h0});
      wb_read(REG_CRC_DAT1, hi);
      wb_read(REG_CRC_DAT0, lo);
      compare_crc($sformatf("CRC lane %0d", l), cleared ? 16'h0000 : ref_crc[l], {hi, lo});
    end
  endtask

  initial begin
    seed     = SEED;
    wb_rst_i = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = 3'd0;
    wb_dat_i = 8'h00;
    sd_cmd_i = 1'b1;
    sd_dat_i = 4'hf;
    for (int l = 0; l < SD_LANES; l++) begin
      ref_crc[l] = '0;
    end
    repeat (5) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    @(negedge wb_clk_i);

    check_reset_state();
    check_readback();
    check_cmd_advance();
    check_byte_write();
    check_byte_read();
    check_crc_lanes(1'b0);
    wb_write(REG_CRC_DAT1, 8'h00);
    check_crc_lanes(1'b1);

    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== rtl/sd_bus_pkg.sv ====
package sd_bus_pkg;

  // SD clock speed select. The half-period grows with the code.
  typedef enum logic [1:0] {
    W_40M  = 2'd0,
    W_20M  = 2'd1,
    W_10M  = 2'd2,
    W_365K = 2'd3
  } sd_clk_width_e;

  typedef enum logic [1:0] {
    ADV_NONE   = 2'd0,
    ADV_DAT_RD = 2'd1,
    ADV_DAT_WR = 2'd2
  } sd_adv_mode_e;

  typedef enum logic {
    DW_1 = 1'b0,
    DW_4 = 1'b1
  } sd_dat_width_e;

  localparam int SD_LANES = 4;
  localparam int SD_CRC_W = 16;

endpackage

// ==== rtl/sd_crc16_bank.sv ====
`timescale 1ns/1ps

module sd_crc16_bank import sd_bus_pkg::*; (
  input  logic                         wb_clk_i,
  input  logic                         wb_rst_i,
  input  logic                         crc_rst_i,
  input  logic                         crc_sample_i,
  input  logic [SD_LANES-1:0]          crc_bits_i,
  input  sd_dat_width_e                crc_lanes_i,
  output logic [SD_LANES*SD_CRC_W-1:0] crc16_o
);

  // CRC16-CCITT, x^16 + x^12 + x^5 + 1.
  localparam logic [SD_CRC_W-1:0] POLY = 16'h1021;

  logic [SD_LANES-1:0][SD_CRC_W-1:0] crc_q;

  function automatic logic [SD_CRC_W-1:0] crc_step(
    input logic [SD_CRC_W-1:0] crc,
    input logic                bit_in
  );
    logic fb;
    fb = crc[SD_CRC_W-1] ^ bit_in;
    return {crc[SD_CRC_W-2:0], 1'b0} ^ (fb ? POLY : '0);
  endfunction

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || crc_rst_i) begin
      crc_q <= '0;
    end else if (crc_sample_i) begin
      for (int n = 0; n < SD_LANES; n++) begin
        // Only lane 0 carries data in 1-bit mode.
        if ((n == 0) || (crc_lanes_i == DW_4)) begin
          crc_q[n] <= crc_step(crc_q[n], crc_bits_i[n]);
        end
      end
    end
  end

  assign crc16_o = crc_q;

endmodule

// ==== rtl/sd_ctrl_if.sv ====
`timescale 1ns/1ps

interface sd_ctrl_if import sd_bus_pkg::*; ();

  sd_adv_mode_e  adv_mode;
  logic          mem_adv_en;
  logic          man_adv_en;
  logic [7:0]    dat_wr;
  logic          cmd_wr;
  logic          dat_oe;
  logic          cmd_oe;
  sd_dat_width_e data_width;
  sd_clk_width_e clk_width;

  // Status back from the line engine.
  logic          mem_adv_done;
  logic          man_adv_done;
  logic          rd_dat_avail;
  logic [7:0]    dat_rd;
  logic [7:0]    cmd_rd;

  modport regs (
    output adv_mode, mem_adv_en, man_adv_en, dat_wr, cmd_wr,
    output dat_oe, cmd_oe, data_width, clk_width,
    input  mem_adv_done, man_adv_done, rd_dat_avail, dat_rd, cmd_rd
  );

  modport engine (
    input  adv_mode, mem_adv_en, man_adv_en, dat_wr, cmd_wr,
    input  dat_oe, cmd_oe, data_width, clk_width,
    output mem_adv_done, man_adv_done, rd_dat_avail, dat_rd, cmd_rd
  );

endinterface

// ==== rtl/sd_host_top.sv ====
`timescale 1ns/1ps

module sd_host_top import sd_reg_pkg::*, sd_bus_pkg::*; #(
  parameter int DIV_SLOW = 55
) (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  logic [2:0]          wb_adr_i,
  input  logic [7:0]          wb_dat_i,
  output logic [7:0]          wb_dat_o,
  output logic                wb_ack_o,

  output logic                sd_clk_o,
  output logic                sd_cmd_o,
  output logic                sd_cmd_oe_o,
  input  logic                sd_cmd_i,
  output logic [SD_LANES-1:0] sd_dat_o,
  output logic                sd_dat_oe_o,
  input  logic [SD_LANES-1:0] sd_dat_i
);

  logic                         crc_sample;
  logic [SD_LANES-1:0]          crc_bits;
  sd_dat_width_e                crc_lanes;
  logic                         crc_rst;
  logic [SD_LANES*SD_CRC_W-1:0] crc16;

  sd_ctrl_if i_ctrl ();

  sd_wb_regs i_regs (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (sd_reg_addr_e'(wb_adr_i)),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .ctrl      (i_ctrl.regs),
    .crc16_i   (crc16),
    .crc_rst_o (crc_rst)
  );

  sd_line_engine #(
    .DIV_SLOW (DIV_SLOW)
  ) i_engine (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .ctrl         (i_ctrl.engine),
    .sd_clk_o     (sd_clk_o),
    .sd_cmd_o     (sd_cmd_o),
    .sd_cmd_oe_o  (sd_cmd_oe_o),
    .sd_cmd_i     (sd_cmd_i),
    .sd_dat_o     (sd_dat_o),
    .sd_dat_oe_o  (sd_dat_oe_o),
    .sd_dat_i     (sd_dat_i),
    .crc_sample_o (crc_sample),
    .crc_bits_o   (crc_bits),
    .crc_lanes_o  (crc_lanes)
  );

  sd_crc16_bank i_crc (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .crc_rst_i    (crc_rst),
    .crc_sample_i (crc_sample),
    .crc_bits_i   (crc_bits),
    .crc_lanes_i  (crc_lanes),
    .crc16_o      (crc16)
  );

endmodule

// ==== rtl/sd_line_engine.sv ====
`timescale 1ns/1ps

module sd_line_engine import sd_bus_pkg::*; #(
  parameter int DIV_SLOW = 55
) (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  sd_ctrl_if.engine           ctrl,
  output logic                sd_clk_o,
  output logic                sd_cmd_o,
  output logic                sd_cmd_oe_o,
  input  logic                sd_cmd_i,
  output logic [SD_LANES-1:0] sd_dat_o,
  output logic                sd_dat_oe_o,
  input  logic [SD_LANES-1:0] sd_dat_i,
  output logic                crc_sample_o,
  output logic [SD_LANES-1:0] crc_bits_o,
  output sd_dat_width_e       crc_lanes_o
);

  localparam int HALF_MAX = (DIV_SLOW > 4) ? DIV_SLOW : 4;
  localparam int CNT_W    = $clog2(HALF_MAX + 1);

  logic                en_q, pend_q, pend_mem_q;
  logic                busy_q, mem_q, rd_q, high_q;
  logic [CNT_W-1:0]    div_cnt_q, half_len;
  logic [3:0]          bits_q;
  logic                mem_done_q, man_done_q, avail_q, sample_q;
  logic                half_end;
  logic [7:0]          sh_q, sh_src, sh_nxt, dat_rd_q, cmd_rd_q;
  logic [SD_LANES-1:0] nib_nxt, dat_out_q, crc_bits_q;
  logic                cmd_out_q;

  always_comb begin
    case (ctrl.clk_width)
      W_40M:   half_len = CNT_W'(1);
      W_20M:   half_len = CNT_W'(2);
      W_10M:   half_len = CNT_W'(4);
      default: half_len = CNT_W'(DIV_SLOW);
    endcase
  end

  assign half_end = busy_q && (div_cnt_q == half_len - 1'b1);

  // Next nibble on the lines. Line 3 takes the top bit.
  assign sh_src = pend_q ? ctrl.dat_wr : sh_q;
  always_comb begin
    if (ctrl.data_width == DW_4) begin
      nib_nxt = sh_src[7:4];
      sh_nxt  = {sh_src[3:0], 4'h0};
    end else begin
      nib_nxt = {3'b111, sh_src[7]};
      sh_nxt  = {sh_src[6:0], 1'b0};
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      {en_q, pend_q, pend_mem_q, busy_q, mem_q, rd_q, high_q} <= '0;
      {mem_done_q, man_done_q, avail_q, sample_q} <= '0;
      div_cnt_q <= '0;
      bits_q    <= 4'd0;
    end else begin
      en_q       <= ctrl.mem_adv_en;
      pend_q     <= 1'b0;
      mem_done_q <= 1'b0;
      sample_q   <= 1'b0;
      if (!busy_q && !pend_q) begin
        if (ctrl.mem_adv_en && !en_q) begin
          pend_q     <= 1'b1;
          pend_mem_q <= 1'b1;
        end else if (ctrl.man_adv_en) begin
          pend_q     <= 1'b1;
          pend_mem_q <= 1'b0;
        end
      end
      if (pend_q) begin
        busy_q    <= 1'b1;
        mem_q     <= pend_mem_q;
        rd_q      <= (ctrl.adv_mode == ADV_DAT_RD);
        high_q    <= 1'b0;
        div_cnt_q <= '0;
        avail_q   <= 1'b0;
        if (pend_mem_q) begin
          bits_q <= (ctrl.data_width == DW_4) ? 4'd2 : 4'd8;
        end else begin
          bits_q     <= 4'd1;
          man_done_q <= 1'b0;
        end
      end else if (half_end) begin
        div_cnt_q <= '0;
        high_q    <= !high_q;
        if (!high_q) begin
          sample_q <= mem_q;
        end else begin
          bits_q <= bits_q - 4'd1;
          if (bits_q == 4'd1) begin
            busy_q     <= 1'b0;
            mem_done_q <= mem_q;
            avail_q    <= mem_q && rd_q;
            man_done_q <= !mem_q || man_done_q;
          end
        end
      end else if (busy_q) begin
        div_cnt_q <= div_cnt_q + 1'b1;
      end
    end
  end

  // Line data is driven at the low half and captured at the rising edge.
  always_ff @(posedge wb_clk_i) begin
    if (pend_q && pend_mem_q && (ctrl.adv_mode == ADV_DAT_WR)) begin
      dat_out_q <= nib_nxt;
      sh_q      <= sh_nxt;
    end else if (pend_q && !pend_mem_q) begin
      cmd_out_q <= ctrl.cmd_wr;
    end else if (half_end && !high_q) begin
      if (mem_q) begin
        crc_bits_q <= rd_q ? sd_dat_i : dat_out_q;
        if (rd_q) begin
          dat_rd_q <= (ctrl.data_width == DW_4) ? {dat_rd_q[3:0], sd_dat_i} :
                                                  {dat_rd_q[6:0], sd_dat_i[0]};
        end
      end else begin
        cmd_rd_q <= {cmd_rd_q[6:0], sd_cmd_i};
      end
    end else if (half_end && mem_q && !rd_q && (bits_q != 4'd1)) begin
      dat_out_q <= nib_nxt;
      sh_q      <= sh_nxt;
    end
  end

  assign sd_clk_o     = high_q;
  assign sd_cmd_o     = cmd_out_q;
  assign sd_cmd_oe_o  = ctrl.cmd_oe;
  assign sd_dat_o     = dat_out_q;
  assign sd_dat_oe_o  = ctrl.dat_oe;
  assign crc_sample_o = sample_q;
  assign crc_bits_o   = crc_bits_q;
  assign crc_lanes_o  = ctrl.data_width;

  assign ctrl.mem_adv_done = mem_done_q;
  assign ctrl.man_adv_done = man_done_q;
  assign ctrl.rd_dat_avail = avail_q;
  assign ctrl.dat_rd       = dat_rd_q;
  assign ctrl.cmd_rd       = cmd_rd_q;

endmodule

// ==== rtl/sd_reg_pkg.sv ====
package sd_reg_pkg;

  // Byte register map on the Wishbone side.
  typedef enum logic [2:0] {
    REG_CMD      = 3'd0,
    REG_DAT      = 3'd1,
    REG_AUTO     = 3'd2,
    REG_ADV      = 3'd3,
    REG_CLK      = 3'd4,
    REG_CRC_CMD  = 3'd5,
    REG_CRC_DAT1 = 3'd6,
    REG_CRC_DAT0 = 3'd7
  } sd_reg_addr_e;

  // CLK register layout.
  typedef struct packed {
    logic [1:0] rsvd_hi;
    logic       dat_oe;
    logic       cmd_oe;
    logic       rsvd_lo;
    logic       data_width;
    logic [1:0] clk_width;
  } sd_clk_reg_t;

  // AUTO layout; CRC_CMD reuses it for the lane select.
  typedef struct packed {
    logic [1:0] rsvd_hi;
    logic [1:0] sel;
    logic [2:0] rsvd_lo;
    logic       avail;
  } sd_auto_reg_t;

  typedef union packed {
    sd_clk_reg_t  clk;
    sd_auto_reg_t adv;
    logic [7:0]   raw;
  } sd_wdata_u;

endpackage

// ==== rtl/sd_wb_regs.sv ====
`timescale 1ns/1ps

module sd_wb_regs import sd_reg_pkg::*, sd_bus_pkg::*; (
  input  logic                         wb_clk_i,
  input  logic                         wb_rst_i,
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  sd_reg_addr_e                 wb_adr_i,
  input  logic [7:0]                   wb_dat_i,
  output logic [7:0]                   wb_dat_o,
  output logic                         wb_ack_o,
  sd_ctrl_if.regs                      ctrl,
  input  logic [SD_LANES*SD_CRC_W-1:0] crc16_i,
  output logic                         crc_rst_o
);

  localparam logic WB_IDLE     = 1'b0;
  localparam logic WB_ADV_WAIT = 1'b1;

  logic          wb_state;
  logic          wb_ack_q;
  logic          wb_trans;
  logic          wb_start;
  logic          wr_start;
  logic          dat_adv_req;

  sd_wdata_u     wdata;
  sd_wdata_u     rdata;
  logic [SD_CRC_W-1:0] crc_lane;

  sd_adv_mode_e  adv_mode_q;
  logic [1:0]    crc_sel_q;
  logic          dat_oe_q;
  logic          cmd_oe_q;
  sd_dat_width_e data_width_q;
  sd_clk_width_e clk_width_q;
  logic          cmd_wr_q;
  logic [7:0]    dat_wr_q;

  assign wb_trans = wb_cyc_i && wb_stb_i;
  // A new access is taken only once the previous ack has gone.
  assign wb_start = wb_trans && !wb_ack_q && (wb_state == WB_IDLE);
  assign wr_start = wb_start && wb_we_i;
  assign wdata    = wdata_cast(wb_dat_i);

  assign dat_adv_req = wb_trans && (wb_adr_i == REG_DAT) &&
                       ((adv_mode_q == ADV_DAT_RD) || (adv_mode_q == ADV_DAT_WR));

  function automatic sd_wdata_u wdata_cast(input logic [7:0] b);
    sd_wdata_u w;
    w.raw = b;
    return w;
  endfunction

  // Ack state machine; advance accesses wait for the engine.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_state <= WB_IDLE;
      wb_ack_q <= 1'b0;
    end else begin
      wb_ack_q <= 1'b0;
      case (wb_state)
        WB_IDLE: begin
          if (wb_start) begin
            if (dat_adv_req) begin
              wb_state <= WB_ADV_WAIT;
            end else begin
              wb_ack_q <= 1'b1;
            end
          end
        end
        default: begin
          if (ctrl.mem_adv_done) begin
            wb_state <= WB_IDLE;
          end
        end
      endcase
    end
  end

  assign wb_ack_o = wb_ack_q || ((wb_state == WB_ADV_WAIT) && ctrl.mem_adv_done);

  // Configuration registers.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      adv_mode_q   <= ADV_NONE;
      crc_sel_q    <= 2'd0;
      dat_oe_q     <= 1'b0;
      cmd_oe_q     <= 1'b0;
      data_width_q <= DW_1;
      clk_width_q  <= W_365K;
    end else if (wr_start) begin
      case (wb_adr_i)
        REG_AUTO: begin
          adv_mode_q <= sd_adv_mode_e'(wdata.adv.sel);
        end
        REG_CLK: begin
          dat_oe_q     <= wdata.clk.dat_oe;
          cmd_oe_q     <= wdata.clk.cmd_oe;
          data_width_q <= sd_dat_width_e'(wdata.clk.data_width);
          clk_width_q  <= sd_clk_width_e'(wdata.clk.clk_width);
        end
        REG_CRC_CMD: begin
          crc_sel_q <= wdata.adv.sel;
        end
        default: begin
        end
      endcase
    end
  end

  // Outgoing command bit and data byte.
  always_ff @(posedge wb_clk_i) begin
    if (wr_start && (wb_adr_i == REG_CMD)) begin
      cmd_wr_q <= wdata.raw[0];
    end
    if (wr_start && (wb_adr_i == REG_DAT)) begin
      dat_wr_q <= wdata.raw;
    end
  end

  assign crc_lane = crc16_i[crc_sel_q*SD_CRC_W +: SD_CRC_W];

  always_comb begin
    rdata.raw = 8'h00;
    case (wb_adr_i)
      REG_CMD:      rdata.raw = ctrl.cmd_rd;
      REG_DAT:      rdata.raw = ctrl.dat_rd;
      REG_AUTO: begin
        rdata.adv.sel   = adv_mode_q;
        rdata.adv.avail = ctrl.rd_dat_avail;
      end
      REG_ADV:      rdata.raw = {7'b0, ctrl.man_adv_done};
      REG_CLK: begin
        rdata.clk.dat_oe     = dat_oe_q;
        rdata.clk.cmd_oe     = cmd_oe_q;
        rdata.clk.data_width = data_width_q;
        rdata.clk.clk_width  = clk_width_q;
      end
      REG_CRC_CMD:  rdata.adv.sel = crc_sel_q;
      REG_CRC_DAT1: rdata.raw = crc_lane[15:8];
      default:      rdata.raw = crc_lane[7:0];
    endcase
  end

  assign wb_dat_o = rdata.raw;

  // Requests to the line engine.
  assign ctrl.mem_adv_en = dat_adv_req && !wb_ack_o;
  assign ctrl.man_adv_en = wr_start && (wb_adr_i == REG_ADV);
  assign crc_rst_o       = wr_start && (wb_adr_i == REG_CRC_DAT1);

  assign ctrl.adv_mode   = adv_mode_q;
  assign ctrl.dat_wr     = dat_wr_q;
  assign ctrl.cmd_wr     = cmd_wr_q;
  assign ctrl.dat_oe     = dat_oe_q;
  assign ctrl.cmd_oe     = cmd_oe_q;
  assign ctrl.data_width = data_width_q;
  assign ctrl.clk_width  = clk_width_q;

endmodule

// ==== verilog.f ====
rtl/sd_bus_pkg.sv
rtl/sd_reg_pkg.sv
rtl/sd_ctrl_if.sv
rtl/sd_wb_regs.sv
rtl/sd_line_engine.sv
rtl/sd_crc16_bank.sv
rtl/sd_host_top.sv
dv/tb_sd_host.sv
